// File: hdl/core_cfg_pkg.sv
// Machine widths for the dispatch stage; WB_WIDTH must equal DISPATCH_WIDTH, one port per lane
package core_cfg_pkg;

	// ================================================
	// Front end and back end widths
	// ================================================

	// Micro-ops accepted from decode per cycle
	parameter int DECODE_WIDTH = 2;

	// Micro-ops leaving the queue per cycle, one per lane
	parameter int DISPATCH_WIDTH = 2;

	// Writeback broadcast ports, one per lane
	parameter int WB_WIDTH = DISPATCH_WIDTH;

	// Physical register file size and tag width
	parameter int PHY_REG_NUM = 32;
	parameter int PREG_W = $clog2(PHY_REG_NUM);

endpackage

// File: hdl/dq_types_pkg.sv
// Entry and enum types for the dispatch stage; opcode needs 2 bits, one encoding is unused
package dq_types_pkg;

	// ================================================
	// Opcodes, latency class of a micro-op
	// ================================================
	typedef enum logic [1:0] {
		OP_ALU  = 2'd0,
		OP_MUL  = 2'd1,
		OP_LOAD = 2'd2
	} opcode_e;

	// Queue entry, 19 bits with 5-bit tags
	// Ready bits are owned by the busy table and the queue wakeup
	typedef struct packed {
		opcode_e                          opcode;
		logic [core_cfg_pkg::PREG_W-1:0] pdest;
		logic [core_cfg_pkg::PREG_W-1:0] src0;
		logic [core_cfg_pkg::PREG_W-1:0] src1;
		logic                             src0_ready;
		logic                             src1_ready;
	} dq_entry_t;

	// Flush sequencer states
	typedef enum logic [1:0] {
		ST_RUN   = 2'd0,
		ST_FLUSH = 2'd1,
		ST_DRAIN = 2'd2
	} seq_state_e;

endpackage

// File: hdl/busy_table.sv
// Destination tags must be unique while in flight; ready bits arriving on in_entry_i are ignored
`timescale 1ns/1ps

module busy_table (
	input  logic clk,
	input  logic rst_n,
	input  logic [core_cfg_pkg::DECODE_WIDTH-1:0] in_valid_i,
	input  dq_types_pkg::dq_entry_t [core_cfg_pkg::DECODE_WIDTH-1:0] in_entry_i,
	input  logic in_ready_i,
	input  logic busy_clear_i,
	input  logic [core_cfg_pkg::WB_WIDTH-1:0] wb_valid_i,
	input  logic [core_cfg_pkg::WB_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0] wb_pdest_i,
	output logic [core_cfg_pkg::DECODE_WIDTH-1:0] dq_write_valid_o,
	output dq_types_pkg::dq_entry_t [core_cfg_pkg::DECODE_WIDTH-1:0] dq_write_entry_o
);

	// One bit per physical register, set while a producer is in flight
	logic [core_cfg_pkg::PHY_REG_NUM-1:0] busy_q, busy_n;
	logic [core_cfg_pkg::DECODE_WIDTH-1:0] accept;
	// High from a clear until intake resumes
	logic post_clear_q;

	// Slots taken this cycle
	assign accept = in_valid_i & {core_cfg_pkg::DECODE_WIDTH{in_ready_i}};
	assign dq_write_valid_o = accept;

	// ================================================
	// Source ready fill-in
	// ================================================
	always_comb begin
		for (int i = 0; i < core_cfg_pkg::DECODE_WIDTH; i++) begin
			dq_write_entry_o[i] = in_entry_i[i];
			// Table lookup
			dq_write_entry_o[i].src0_ready = !busy_q[in_entry_i[i].src0];
			dq_write_entry_o[i].src1_ready = !busy_q[in_entry_i[i].src1];
			// Same-cycle writeback bypass
			for (int j = 0; j < core_cfg_pkg::WB_WIDTH; j++) begin
				if (wb_valid_i[j] && wb_pdest_i[j] == in_entry_i[i].src0) begin
					dq_write_entry_o[i].src0_ready = 1'b1;
				end
				if (wb_valid_i[j] && wb_pdest_i[j] == in_entry_i[i].src1) begin
					dq_write_entry_o[i].src1_ready = 1'b1;
				end
			end
			// Older producer in the same group wins over the bypass
			for (int k = 0; k < i; k++) begin
				if (accept[k] && in_entry_i[k].pdest == in_entry_i[i].src0) begin
					dq_write_entry_o[i].src0_ready = 1'b0;
				end
				if (accept[k] && in_entry_i[k].pdest == in_entry_i[i].src1) begin
					dq_write_entry_o[i].src1_ready = 1'b0;
				end
			end
		end
	end

	// ================================================
	// Busy bit update
	// ================================================
	always_comb begin
		busy_n = busy_q;
		// Writebacks release their tag
		for (int j = 0; j < core_cfg_pkg::WB_WIDTH; j++) begin
			if (wb_valid_i[j]) begin
				busy_n[wb_pdest_i[j]] = 1'b0;
			end
		end
		// New producers, after release so a recycled tag stays busy
		for (int i = 0; i < core_cfg_pkg::DECODE_WIDTH; i++) begin
			if (accept[i]) begin
				busy_n[in_entry_i[i].pdest] = 1'b1;
			end
		end
		if (busy_clear_i) begin
			busy_n = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q       <= '0;
			post_clear_q <= 1'b0;
		end else begin
			busy_q <= busy_n;
			if (busy_clear_i) begin
				post_clear_q <= 1'b1;
			end else if (|accept) begin
				post_clear_q <= 1'b0;
			end
		end
	end

	// Writeback from the lanes must hit a register the table marked busy
	for (genvar j = 0; j < core_cfg_pkg::WB_WIDTH; j++) begin : g_wb_chk
		a_wb_busy: assert property (@(posedge clk) disable iff (!rst_n)
			wb_valid_i[j] && !post_clear_q |-> busy_q[wb_pdest_i[j]]);
	end

endmodule

// File: hdl/dispatch_queue.sv
// QUEUE_DEPTH must be a power of two and at least DECODE_WIDTH; reads must be a low-slot prefix
`timescale 1ns/1ps

module dispatch_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	input  logic [core_cfg_pkg::DECODE_WIDTH-1:0] write_valid_i,
	input  dq_types_pkg::dq_entry_t [core_cfg_pkg::DECODE_WIDTH-1:0] write_data_i,
	output logic write_ready_o,
	output logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_valid_o,
	output dq_types_pkg::dq_entry_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_data_o,
	input  logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_ready_i,
	input  logic [core_cfg_pkg::WB_WIDTH-1:0] wb_i,
	input  logic [core_cfg_pkg::WB_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0] wb_pdest_i
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage
	dq_types_pkg::dq_entry_t [QUEUE_DEPTH-1:0] mem_q, mem_n;
	// Control state
	logic [PTR_W-1:0] head_q, head_n;
	logic [PTR_W-1:0] tail_q, tail_n;
	logic [CNT_W-1:0] cnt_q, cnt_n;
	// Per-cycle traffic
	logic [CNT_W-1:0] write_cnt, read_cnt;
	logic [PTR_W-1:0] wr_ptr;

	// Room for a full decode group
	assign write_ready_o = cnt_q <= CNT_W'(QUEUE_DEPTH - core_cfg_pkg::DECODE_WIDTH);

	// ================================================
	// Head side, oldest entries first
	// ================================================
	always_comb begin
		for (int i = 0; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
			read_valid_o[i] = cnt_q > CNT_W'(i);
			read_data_o[i]  = mem_q[head_q + PTR_W'(i)];
		end
	end

	// ================================================
	// Next state
	// ================================================
	always_comb begin
		mem_n = mem_q;

		// Tag wakeup on stored entries
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			for (int j = 0; j < core_cfg_pkg::WB_WIDTH; j++) begin
				if (wb_i[j] && mem_q[i].src0 == wb_pdest_i[j]) begin
					mem_n[i].src0_ready = 1'b1;
				end
				if (wb_i[j] && mem_q[i].src1 == wb_pdest_i[j]) begin
					mem_n[i].src1_ready = 1'b1;
				end
			end
		end

		// Tail writes, packed so a gap in the valid bits leaves no hole
		write_cnt = '0;
		wr_ptr    = tail_q;
		for (int i = 0; i < core_cfg_pkg::DECODE_WIDTH; i++) begin
			if (write_valid_i[i] && write_ready_o) begin
				mem_n[wr_ptr] = write_data_i[i];
				wr_ptr        = wr_ptr + 1'b1;
				write_cnt     = write_cnt + 1'b1;
			end
		end

		// Slots leaving at the head
		read_cnt = '0;
		for (int i = 0; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
			read_cnt = read_cnt + CNT_W'(read_ready_i[i] & read_valid_o[i]);
		end

		head_n = head_q + PTR_W'(read_cnt);
		tail_n = wr_ptr;
		cnt_n  = cnt_q + write_cnt - read_cnt;

		// Flush drops everything, including this cycle's writes
		if (flush_i) begin
			head_n = '0;
			tail_n = '0;
			cnt_n  = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			head_q <= head_n;
			tail_q <= tail_n;
			cnt_q  <= cnt_n;
		end
	end

	always_ff @(posedge clk) begin
		mem_q <= mem_n;
	end

	a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_q <= CNT_W'(QUEUE_DEPTH));

	// Select logic must never pull an empty slot
	a_read_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(read_ready_i & ~read_valid_o) == '0);

endmodule

// File: hdl/dispatch_select.sv
// Purely combinational; slot i always goes to lane i, so a blocked slot stalls every younger one
`timescale 1ns/1ps

module dispatch_select (
	input  logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_valid_i,
	input  dq_types_pkg::dq_entry_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_entry_i,
	input  logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] lane_free_i,
	input  logic dispatch_en_i,
	output logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_ready_o,
	output logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] issue_valid_o,
	output dq_types_pkg::dq_entry_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] issue_entry_o
);

	// Slot may go on its own merits
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] can_go;
	// Slot goes, with every older slot going too
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] fire;

	always_comb begin
		for (int i = 0; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
			can_go[i] = read_valid_i[i] && read_entry_i[i].src0_ready
				&& read_entry_i[i].src1_ready && lane_free_i[i] && dispatch_en_i;
		end
		// In-order chain from the head
		fire[0] = can_go[0];
		for (int i = 1; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
			fire[i] = can_go[i] && fire[i-1];
		end
	end

	// Pop from the queue and launch into the lane together
	assign read_ready_o  = fire;
	assign issue_valid_o = fire;
	assign issue_entry_o = read_entry_i;

endmodule

// File: hdl/exec_timer.sv
// All latencies must be at least 1 and LAT_LOAD the largest; lane i reports on writeback port i
`timescale 1ns/1ps

module exec_timer #(
	parameter int LAT_ALU  = 1,
	parameter int LAT_MUL  = 3,
	parameter int LAT_LOAD = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] issue_valid_i,
	input  dq_types_pkg::dq_entry_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] issue_entry_i,
	output logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] lane_free_o,
	output logic lanes_idle_o,
	output logic [core_cfg_pkg::WB_WIDTH-1:0] wb_valid_o,
	output logic [core_cfg_pkg::WB_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0] wb_pdest_o
);

	localparam int CNT_W = $clog2(LAT_LOAD + 1);

	// Zero means idle, one means writeback this cycle
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0][CNT_W-1:0] cnt_q;
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0] pdest_q;

	// Opcode to cycle count
	function automatic logic [CNT_W-1:0] op_latency(input dq_types_pkg::opcode_e op);
		case (op)
			dq_types_pkg::OP_MUL:  op_latency = CNT_W'(LAT_MUL);
			dq_types_pkg::OP_LOAD: op_latency = CNT_W'(LAT_LOAD);
			default:               op_latency = CNT_W'(LAT_ALU);
		endcase
	endfunction

	// ================================================
	// Lane counters
	// ================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
				if (issue_valid_i[i]) begin
					cnt_q[i] <= op_latency(issue_entry_i[i].opcode);
				end else if (cnt_q[i] != '0) begin
					cnt_q[i] <= cnt_q[i] - 1'b1;
				end
			end
		end
	end

	// Tag held for the broadcast
	always_ff @(posedge clk) begin
		for (int i = 0; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
			if (issue_valid_i[i]) begin
				pdest_q[i] <= issue_entry_i[i].pdest;
			end
		end
	end

	always_comb begin
		lanes_idle_o = 1'b1;
		for (int i = 0; i < core_cfg_pkg::DISPATCH_WIDTH; i++) begin
			wb_valid_o[i] = cnt_q[i] == CNT_W'(1);
			wb_pdest_o[i] = pdest_q[i];
			// Free in the writeback cycle, so back-to-back issue is possible
			lane_free_o[i] = cnt_q[i] == '0 || wb_valid_o[i];
			if (cnt_q[i] != '0) begin
				lanes_idle_o = 1'b0;
			end
		end
	end

	// Select must respect lane occupancy
	a_issue_free: assert property (@(posedge clk) disable iff (!rst_n)
		(issue_valid_i & ~lane_free_o) == '0);

endmodule

// File: hdl/flush_fsm.sv
// flush_req_i is a one-cycle pulse; a request outside ST_RUN is dropped
`timescale 1ns/1ps

module flush_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_req_i,
	input  logic write_ready_i,
	input  logic lanes_idle_i,
	output logic in_ready_o,
	output logic dispatch_en_o,
	output logic q_flush_o,
	output logic busy_clear_o
);

	dq_types_pkg::seq_state_e state_q, state_n;

	// ================================================
	// Run, flush, drain
	// ================================================
	always_comb begin
		state_n = state_q;
		case (state_q)
			dq_types_pkg::ST_RUN: begin
				if (flush_req_i) begin
					state_n = dq_types_pkg::ST_FLUSH;
				end
			end
			// Single cycle of clearing
			dq_types_pkg::ST_FLUSH: state_n = dq_types_pkg::ST_DRAIN;
			// Wait out whatever is still executing
			dq_types_pkg::ST_DRAIN: begin
				if (lanes_idle_i) begin
					state_n = dq_types_pkg::ST_RUN;
				end
			end
			default: state_n = dq_types_pkg::ST_RUN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= dq_types_pkg::ST_RUN;
		end else begin
			state_q <= state_n;
		end
	end

	// Intake and dispatch only while running
	assign in_ready_o    = state_q == dq_types_pkg::ST_RUN && write_ready_i;
	assign dispatch_en_o = state_q == dq_types_pkg::ST_RUN;
	assign q_flush_o     = state_q == dq_types_pkg::ST_FLUSH;
	assign busy_clear_o  = state_q == dq_types_pkg::ST_FLUSH;

	a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state_q inside {dq_types_pkg::ST_RUN, dq_types_pkg::ST_FLUSH, dq_types_pkg::ST_DRAIN});

endmodule

// File: hdl/dispatch_core_top.sv
// Caller supplies unique destination tags; no renaming, operand values or partial recovery
`timescale 1ns/1ps

module dispatch_core_top #(
	parameter int QUEUE_DEPTH = 8,
	parameter int LAT_ALU     = 1,
	parameter int LAT_MUL     = 3,
	parameter int LAT_LOAD    = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [core_cfg_pkg::DECODE_WIDTH-1:0] in_valid_i,
	input  dq_types_pkg::dq_entry_t [core_cfg_pkg::DECODE_WIDTH-1:0] in_entry_i,
	output logic in_ready_o,
	input  logic flush_req_i,
	output logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] issue_valid_o,
	output dq_types_pkg::dq_entry_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] issue_entry_o,
	output logic [core_cfg_pkg::WB_WIDTH-1:0] wb_valid_o,
	output logic [core_cfg_pkg::WB_WIDTH-1:0][core_cfg_pkg::PREG_W-1:0] wb_pdest_o
);

	// ================================================
	// Internal nets
	// ================================================
	// Busy table to queue
	logic [core_cfg_pkg::DECODE_WIDTH-1:0] dq_write_valid;
	dq_types_pkg::dq_entry_t [core_cfg_pkg::DECODE_WIDTH-1:0] dq_write_entry;
	// Queue head and select
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_valid;
	dq_types_pkg::dq_entry_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_entry;
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] read_ready;
	logic write_ready;
	// Lane status
	logic [core_cfg_pkg::DISPATCH_WIDTH-1:0] lane_free;
	logic lanes_idle;
	// Sequencer controls
	logic dispatch_en, q_flush, busy_clear;

	busy_table u_busy_table (
		.clk(clk), .rst_n(rst_n),
		.in_valid_i(in_valid_i), .in_entry_i(in_entry_i), .in_ready_i(in_ready_o),
		.busy_clear_i(busy_clear), .wb_valid_i(wb_valid_o), .wb_pdest_i(wb_pdest_o),
		.dq_write_valid_o(dq_write_valid), .dq_write_entry_o(dq_write_entry)
	);

	dispatch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dispatch_queue (
		.clk(clk), .rst_n(rst_n), .flush_i(q_flush),
		.write_valid_i(dq_write_valid), .write_data_i(dq_write_entry),
		.write_ready_o(write_ready),
		.read_valid_o(read_valid), .read_data_o(read_entry), .read_ready_i(read_ready),
		.wb_i(wb_valid_o), .wb_pdest_i(wb_pdest_o)
	);

	dispatch_select u_dispatch_select (
		.read_valid_i(read_valid), .read_entry_i(read_entry), .lane_free_i(lane_free),
		.dispatch_en_i(dispatch_en), .read_ready_o(read_ready),
		.issue_valid_o(issue_valid_o), .issue_entry_o(issue_entry_o)
	);

	exec_timer #(.LAT_ALU(LAT_ALU), .LAT_MUL(LAT_MUL), .LAT_LOAD(LAT_LOAD)) u_exec_timer (
		.clk(clk), .rst_n(rst_n),
		.issue_valid_i(issue_valid_o), .issue_entry_i(issue_entry_o),
		.lane_free_o(lane_free), .lanes_idle_o(lanes_idle),
		.wb_valid_o(wb_valid_o), .wb_pdest_o(wb_pdest_o)
	);

	flush_fsm u_flush_fsm (
		.clk(clk), .rst_n(rst_n), .flush_req_i(flush_req_i),
		.write_ready_i(write_ready), .lanes_idle_i(lanes_idle),
		.in_ready_o(in_ready_o), .dispatch_en_o(dispatch_en),
		.q_flush_o(q_flush), .busy_clear_o(busy_clear)
	);

endmodule

// File: tests/tb_dispatch_core.sv
// Latencies and depth below must match the values passed to u_dut; one fixed seed drives the run
`timescale 1ns/1ps

module tb_dispatch_core;

	localparam int QD         = 8;
	localparam int LAT_ALU    = 1;
	localparam int LAT_MUL    = 3;
	localparam int LAT_LOAD   = 4;
	localparam int DW         = core_cfg_pkg::DECODE_WIDTH;
	localparam int NL         = core_cfg_pkg::DISPATCH_WIDTH;
	localparam int NW         = core_cfg_pkg::WB_WIDTH;
	localparam int NR         = core_cfg_pkg::PHY_REG_NUM;
	localparam int PW         = core_cfg_pkg::PREG_W;
	localparam int RUN_CYCLES = 2000;
	localparam int FLUSH_GAP  = 300;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst_n;
	logic [DW-1:0] in_valid_i;
	dq_types_pkg::dq_entry_t [DW-1:0] in_entry_i;
	logic in_ready_o;
	logic flush_req_i;
	logic [NL-1:0] issue_valid_o;
	dq_types_pkg::dq_entry_t [NL-1:0] issue_entry_o;
	logic [NW-1:0] wb_valid_o;
	logic [NW-1:0][PW-1:0] wb_pdest_o;

	// ================================================
	// Reference model state
	// ================================================
	integer seed;
	int cyc;
	// Accepted micro-ops in program order with model-kept ready bits
	dq_types_pkg::dq_entry_t model_q[$];
	// Tags whose producer has not written back yet
	logic [NR-1:0] pending;
	logic [PW-1:0] free_tags[$];
	logic [PW-1:0] recent_tags[$];
	logic [PW-1:0] dropped_tags[$];
	// One micro-op per lane with its expected writeback cycle
	logic [NL-1:0] lane_active;
	int lane_due[NL];
	logic [PW-1:0] lane_tag[NL];

	dispatch_core_top #(
		.QUEUE_DEPTH(QD), .LAT_ALU(LAT_ALU), .LAT_MUL(LAT_MUL), .LAT_LOAD(LAT_LOAD)
	) u_dut (
		.clk(clk), .rst_n(rst_n),
		.in_valid_i(in_valid_i), .in_entry_i(in_entry_i), .in_ready_o(in_ready_o),
		.flush_req_i(flush_req_i),
		.issue_valid_o(issue_valid_o), .issue_entry_o(issue_entry_o),
		.wb_valid_o(wb_valid_o), .wb_pdest_o(wb_pdest_o)
	);

	always #2 clk = ~clk;

	// ================================================
	// Failure reporting and compares
	// ================================================
	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_problem(input string msg);
		$display("t=%0t: %s", $time, msg);
		stop_with_fail();
	endtask

	function automatic string format_entry(input dq_types_pkg::dq_entry_t e);
		return $sformatf("op=%0d pdest=%0d src0=%0d src1=%0d rdy=%b%b",
			e.opcode, e.pdest, e.src0, e.src1, e.src0_ready, e.src1_ready);
	endfunction

	task automatic check_entry(input string name, input dq_types_pkg::dq_entry_t exp,
		input dq_types_pkg::dq_entry_t act);
		if (act !== exp) begin
			$display("ERROR t=%0t %s expected %s actual %s", $time, name,
				format_entry(exp), format_entry(act));
			stop_with_fail();
		end
	endtask

	task automatic check_tag(input string name, input logic [PW-1:0] exp,
		input logic [PW-1:0] act);
		if (act !== exp) begin
			$display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			stop_with_fail();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
			stop_with_fail();
		end
	endtask

	// ================================================
	// Model helpers
	// ================================================
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic int latency_of(input dq_types_pkg::opcode_e op);
		case (op)
			dq_types_pkg::OP_MUL:  return LAT_MUL;
			dq_types_pkg::OP_LOAD: return LAT_LOAD;
			default:               return LAT_ALU;
		endcase
	endfunction

	// Recent producers give dependencies and free tags give idle sources
	function automatic logic [PW-1:0] pick_source();
		if (recent_tags.size() > 0 && rand_below(2) == 0) begin
			return recent_tags[rand_below(recent_tags.size())];
		end
		return free_tags[rand_below(free_tags.size())];
	endfunction

	// Writeback releases the tag and wakes waiting consumers
	function automatic void wake_tag(input logic [PW-1:0] tag);
		pending[tag] = 1'b0;
		foreach (model_q[k]) begin
			if (model_q[k].src0 == tag) begin
				model_q[k].src0_ready = 1'b1;
			end
			if (model_q[k].src1 == tag) begin
				model_q[k].src1_ready = 1'b1;
			end
		end
		free_tags.push_back(tag);
	endfunction

	// Sources look at pending before this slot's own pdest is marked
	function automatic void accept_entry(input dq_types_pkg::dq_entry_t e);
		dq_types_pkg::dq_entry_t m;
		m = e;
		m.src0_ready = !pending[e.src0];
		m.src1_ready = !pending[e.src1];
		pending[e.pdest] = 1'b1;
		model_q.push_back(m);
		recent_tags.push_back(e.pdest);
		if (recent_tags.size() > 4) begin
			void'(recent_tags.pop_front());
		end
	endfunction

	// ================================================
	// Per-cycle output checks at the falling edge
	// ================================================
	task automatic check_outputs(input bit running);
		dq_types_pkg::dq_entry_t exp [NL];
		// Intake follows occupancy at the start of the cycle
		if (running) begin
			check_bit("in_ready_o", model_q.size() <= QD - DW, in_ready_o);
		end else begin
			check_bit("in_ready_o", 1'b0, in_ready_o);
			for (int l = 0; l < NL; l++) begin
				check_bit($sformatf("issue_valid_o[%0d]", l), 1'b0, issue_valid_o[l]);
			end
		end
		// Writeback exactly at the due cycle
		for (int l = 0; l < NL; l++) begin
			check_bit($sformatf("wb_valid_o[%0d]", l),
				lane_active[l] && lane_due[l] == cyc, wb_valid_o[l]);
			if (wb_valid_o[l]) begin
				check_tag($sformatf("wb_pdest_o[%0d]", l), lane_tag[l], wb_pdest_o[l]);
			end
		end
		// Issues must match the model head from the low lane up
		for (int l = 0; l < NL; l++) begin
			if (issue_valid_o[l]) begin
				if (l > 0 && !issue_valid_o[l-1]) begin
					report_problem($sformatf("lane %0d issued while a lower lane did not", l));
				end
				if (lane_active[l] && lane_due[l] != cyc) begin
					report_problem($sformatf("lane %0d issued while still executing", l));
				end
				if (model_q.size() == 0) begin
					report_problem("issue seen with no accepted micro-op waiting");
				end else begin
					exp[l] = model_q.pop_front();
					check_entry($sformatf("issue_entry_o[%0d]", l), exp[l], issue_entry_o[l]);
				end
			end
		end
		for (int l = 0; l < NL; l++) begin
			if (wb_valid_o[l]) begin
				lane_active[l] = 1'b0;
				wake_tag(lane_tag[l]);
			end
		end
		for (int l = 0; l < NL; l++) begin
			if (issue_valid_o[l]) begin
				lane_active[l] = 1'b1;
				lane_due[l]    = cyc + latency_of(exp[l].opcode);
				lane_tag[l]    = exp[l].pdest;
			end
		end
	endtask

	// ================================================
	// Stimulus
	// ================================================
	task automatic drive_inputs(input bit offer);
		dq_types_pkg::dq_entry_t e;
		int used;
		used = 0;
		for (int s = 0; s < DW; s++) begin
			e = '0;
			in_valid_i[s] = 1'b0;
			if (offer && free_tags.size() > used && rand_below(4) != 0) begin
				e.opcode = dq_types_pkg::opcode_e'(rand_below(3));
				e.pdest  = free_tags[used];
				e.src0   = pick_source();
				e.src1   = pick_source();
				// Junk ready bits that the DUT replaces
				e.src0_ready  = rand_below(2) == 1;
				e.src1_ready  = rand_below(2) == 1;
				in_valid_i[s] = 1'b1;
				used++;
				if (in_ready_o) begin
					accept_entry(e);
				end
			end
			in_entry_i[s] = e;
		end
		// Offered tags are only consumed when taken
		if (in_ready_o) begin
			repeat (used) void'(free_tags.pop_front());
		end
	endtask

	task automatic step_cycle(input bit running, input bit offer);
		@(negedge clk);
		cyc++;
		flush_req_i = 1'b0;
		check_outputs(running);
		drive_inputs(offer);
	endtask

	// Flush with an empty decode group and drain until intake reopens
	task automatic flush_and_drain();
		int waited;
		int drain_end;
		int reopen_cyc;
		flush_req_i = 1'b1;
		drive_inputs(1'b0);
		foreach (model_q[k]) begin
			pending[model_q[k].pdest] = 1'b0;
			dropped_tags.push_back(model_q[k].pdest);
		end
		model_q.delete();
		// Last writeback still owed by the lanes
		drain_end = cyc;
		for (int l = 0; l < NL; l++) begin
			if (lane_active[l] && lane_due[l] > drain_end) begin
				drain_end = lane_due[l];
			end
		end
		// Flush cycle first, then one drain cycle with idle lanes
		reopen_cyc = (drain_end + 2 > cyc + 3) ? drain_end + 2 : cyc + 3;
		waited = 0;
		while (lane_active != '0) begin
			step_cycle(1'b0, 1'b1);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_problem("lanes never drained after the flush");
			end
		end
		while (dropped_tags.size() > 0) begin
			free_tags.push_back(dropped_tags.pop_front());
		end
		waited = 0;
		do begin
			@(negedge clk);
			cyc++;
			flush_req_i = 1'b0;
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_problem("intake did not reopen after the drain");
			end
			check_outputs(cyc >= reopen_cyc);
			drive_inputs(1'b1);
		end while (!in_ready_o);
	endtask

	// ================================================
	// Main sequence
	// ================================================
	initial begin
		int waited;
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid_i  = '0;
		in_entry_i  = '0;
		flush_req_i = 1'b0;
		seed        = 32'hbc76_3854;
		cyc         = 0;
		pending     = '0;
		lane_active = '0;
		foreach (lane_due[l]) begin
			lane_due[l] = 0;
			lane_tag[l] = '0;
		end
		for (int t = 0; t < NR; t++) begin
			free_tags.push_back(PW'(t));
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		for (int c = 0; c < RUN_CYCLES; c++) begin
			@(negedge clk);
			cyc++;
			check_outputs(1'b1);
			if (c % FLUSH_GAP == FLUSH_GAP - 1) begin
				flush_and_drain();
			end else begin
				drive_inputs(1'b1);
			end
		end

		// Let the queue and lanes empty out
		waited = 0;
		while (model_q.size() > 0 || lane_active != '0) begin
			step_cycle(1'b1, 1'b0);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_problem("queue and lanes did not empty at the end of the run");
			end
		end

		// Every tag comes home once nothing is in flight
		if (free_tags.size() == NR) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			report_problem("physical tags were lost over the run");
		end
	end

endmodule

// File: dispatch_core.f
hdl/core_cfg_pkg.sv
hdl/dq_types_pkg.sv
hdl/busy_table.sv
hdl/dispatch_queue.sv
hdl/dispatch_select.sv
hdl/exec_timer.sv
hdl/flush_fsm.sv
hdl/dispatch_core_top.sv
tests/tb_dispatch_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the dispatch core testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dispatch_core \
	-f dispatch_core.f -o sim_dispatch_core > build.log 2>&1 \
	|| { cat build.log; echo "run_sim: build failed"; exit 1; }
./obj_dir/sim_dispatch_core > sim.log 2>&1 || echo "run_sim: simulator returned an error"
cat sim.log
grep -qx "Simulation finished: PASS" sim.log \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }
